// ==== src/pool_config.svh ====
`ifndef POOL_CONFIG_SVH
`define POOL_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Unsigned pixel
`define POOL_PIXEL_W 16

// Row and column counts
`define POOL_DIM_W 8

// Feature map count
`define POOL_MAP_W 8

////////////////////////////////////////////////////////////////////////////
// Sizing
////////////////////////////////////////////////////////////////////////////

// Widest image, also the depth of each row memory
`define POOL_MAX_COLS 32

// Entries in the input and output FIFOs
`define POOL_FIFO_DEPTH 16

// Column in to result out; doubles as the output almost-full margin
`define POOL_PIPE_DEPTH 4

`endif

// ==== src/pool_cmd_pkg.sv ====
`default_nettype none

`include "pool_config.svh"

package pool_cmd_pkg;

    // Pooling command as presented on the opcode port
    typedef struct packed {
        logic [`POOL_DIM_W-1:0] img_rows;
        logic [`POOL_DIM_W-1:0] img_cols;
        logic [`POOL_MAP_W-1:0] num_maps;
    } pool_cmd_t;

    // Command controller states
    typedef enum logic [1:0] {
        IDLE,
        START_MAP,
        WAIT_MAP
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/pixel_pkg.sv ====
`default_nettype none

`include "pool_config.svh"

package pixel_pkg;

    typedef logic [`POOL_PIXEL_W-1:0] pixel_t;

    // One vertical slice of the 3x3 window, top row first
    typedef struct packed {
        pixel_t top;
        pixel_t mid;
        pixel_t bottom;
    } pixel_col_t;

    // Result word, last marks the final window of a map
    typedef struct packed {
        pixel_t value;
        logic   last;
    } pool_out_t;

endpackage

`default_nettype wire

// ==== src/stream_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16,
    parameter int  AF_MARGIN = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     empty,
    output logic     full,
    output logic     almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  used;
    logic              do_wr;
    logic              do_rd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // Entry written this cycle already counts as taken
    assign used        = count + CNT_W'(do_wr);
    assign almost_full = (DEPTH - int'(used)) <= AF_MARGIN;

    // Head of the queue is always on the read port
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/pool_cmd_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module pool_cmd_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  pool_cmd_pkg::pool_cmd_t opcode,
    input  logic                    opcode_valid,
    input  logic                    res_valid,
    input  logic                    res_last,
    output logic                    opcode_accept,
    output logic                    opcode_complete,
    output pool_cmd_pkg::pool_cmd_t cmd,
    output logic                    map_start
);

    import pool_cmd_pkg::*;

    ctrl_state_t            state;
    logic [`POOL_MAP_W-1:0] map_cnt;
    logic                   map_done;

    // Final window of the running map has reached the output FIFO
    assign map_done = res_valid && res_last;

    // Command register, loaded as the command is taken
    always_ff @(posedge clk) begin
        if (state == IDLE && opcode_valid) begin
            cmd <= opcode;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Map sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= IDLE;
            map_cnt         <= '0;
            opcode_accept   <= 1'b0;
            opcode_complete <= 1'b0;
            map_start       <= 1'b0;
        end else begin
            opcode_accept   <= 1'b0;
            opcode_complete <= 1'b0;
            map_start       <= 1'b0;
            case (state)
                IDLE: begin
                    if (opcode_valid) begin
                        opcode_accept <= 1'b1;
                        map_cnt       <= '0;
                        state         <= START_MAP;
                    end
                end
                START_MAP: begin
                    map_start <= 1'b1;
                    state     <= WAIT_MAP;
                end
                WAIT_MAP: begin
                    if (map_done) begin
                        if (map_cnt == cmd.num_maps - 1'b1) begin
                            opcode_complete <= 1'b1;
                            state           <= IDLE;
                        end else begin
                            // Next map reuses the same geometry
                            map_cnt <= map_cnt + 1'b1;
                            state   <= START_MAP;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module line_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  pool_cmd_pkg::pool_cmd_t cmd,
    input  logic                    map_start,
    input  pixel_pkg::pixel_t       in_pixel,
    input  logic                    in_empty,
    input  logic                    out_almost_full,
    output logic                    in_pop,
    output pixel_pkg::pixel_col_t   col,
    output logic                    col_valid,
    output logic                    win_valid,
    output logic                    win_last
);

    import pixel_pkg::*;

    localparam int ADDR_W = $clog2(`POOL_MAX_COLS);
    localparam int DIM_W  = `POOL_DIM_W;

    // Row memories: row1 holds the row above, row2 the one above that
    pixel_t row1_mem [`POOL_MAX_COLS];
    pixel_t row2_mem [`POOL_MAX_COLS];

    logic              active;
    logic [DIM_W-1:0]  row_cnt;
    logic [DIM_W-1:0]  col_cnt;
    logic [ADDR_W-1:0] addr;
    logic              row_end;
    logic              map_end;
    pixel_t            above1;
    pixel_t            above2;

    // Take a pixel only when the output side can absorb the pipeline
    assign in_pop = active && !in_empty && !out_almost_full;

    assign addr    = col_cnt[ADDR_W-1:0];
    assign row_end = (col_cnt == cmd.img_cols - 1'b1);
    assign map_end = row_end && (row_cnt == cmd.img_rows - 1'b1);

    assign above1 = row1_mem[addr];
    assign above2 = row2_mem[addr];

    ////////////////////////////////////////////////////////////////////////////
    // Row storage and column output
    ////////////////////////////////////////////////////////////////////////////

    // Shift the popped column one row down
    always_ff @(posedge clk) begin
        if (in_pop) begin
            row2_mem[addr] <= above1;
            row1_mem[addr] <= in_pixel;
        end
    end

    // New pixel enters at the bottom of the column
    always_ff @(posedge clk) begin
        if (in_pop) begin
            col <= '{top: above2, mid: above1, bottom: in_pixel};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Raster counters and window flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            row_cnt   <= '0;
            col_cnt   <= '0;
            col_valid <= 1'b0;
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end else begin
            col_valid <= in_pop;
            // Full 3x3 window once two rows and two columns are behind us
            win_valid <= in_pop && (row_cnt >= DIM_W'(2)) && (col_cnt >= DIM_W'(2));
            win_last  <= in_pop && map_end;

            if (map_start) begin
                active <= 1'b1;
            end

            if (in_pop) begin
                if (map_end) begin
                    active  <= 1'b0;
                    row_cnt <= '0;
                    col_cnt <= '0;
                end else if (row_end) begin
                    col_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/window_max.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module window_max (
    input  logic                  clk,
    input  logic                  rst,
    input  pixel_pkg::pixel_col_t col,
    input  logic                  col_valid,
    input  logic                  win_valid,
    input  logic                  win_last,
    output pixel_pkg::pool_out_t  res,
    output logic                  res_valid
);

    import pixel_pkg::*;

    localparam int PIPE = `POOL_PIPE_DEPTH;

    // Two older columns; the incoming one completes the window
    pixel_col_t      col_d1;
    pixel_col_t      col_d2;
    pixel_t          win [9];
    pixel_t          lvl1 [5];
    pixel_t          lvl2 [3];
    pixel_t          lvl3 [2];
    pixel_t          res_value;
    logic [PIPE-1:0] vld_sr;
    logic [PIPE-1:0] last_sr;

    function automatic pixel_t max2(input pixel_t a, input pixel_t b);
        return (a > b) ? a : b;
    endfunction

    always_ff @(posedge clk) begin
        if (col_valid) begin
            col_d1 <= col;
            col_d2 <= col_d1;
        end
    end

    assign win = '{col.top,    col.mid,    col.bottom,
                   col_d1.top, col_d1.mid, col_d1.bottom,
                   col_d2.top, col_d2.mid, col_d2.bottom};

    ////////////////////////////////////////////////////////////////////////////
    // Compare tree, 9 -> 5 -> 3 -> 2 -> 1
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            lvl1[i] <= max2(win[2*i], win[2*i+1]);
        end
        lvl1[4] <= win[8];

        lvl2[0] <= max2(lvl1[0], lvl1[1]);
        lvl2[1] <= max2(lvl1[2], lvl1[3]);
        lvl2[2] <= lvl1[4];

        lvl3[0] <= max2(lvl2[0], lvl2[1]);
        lvl3[1] <= lvl2[2];

        res_value <= max2(lvl3[0], lvl3[1]);
    end

    // Flags ride alongside the tree, one bit per stage
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr  <= '0;
            last_sr <= '0;
        end else begin
            vld_sr  <= {vld_sr[PIPE-2:0], col_valid && win_valid};
            last_sr <= {last_sr[PIPE-2:0], col_valid && win_last};
        end
    end

    assign res       = '{value: res_value, last: last_sr[PIPE-1]};
    assign res_valid = vld_sr[PIPE-1];

endmodule

`default_nettype wire

// ==== src/pool_engine_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module pool_engine_top (
    input  logic                    clk,
    input  logic                    rst,
    input  pool_cmd_pkg::pool_cmd_t opcode,
    input  logic                    opcode_valid,
    output logic                    opcode_accept,
    output logic                    opcode_complete,
    input  pixel_pkg::pixel_t       datain,
    input  logic                    datain_valid,
    output logic                    datain_ready,
    output pixel_pkg::pool_out_t    dataout,
    output logic                    dataout_valid,
    input  logic                    dataout_ready
);

    import pool_cmd_pkg::*;
    import pixel_pkg::*;

    pixel_t     in_head;
    logic       in_empty;
    logic       in_full;
    logic       in_pop;
    pool_cmd_t  cmd;
    logic       map_start;
    pixel_col_t col;
    logic       col_valid;
    logic       win_valid;
    logic       win_last;
    pool_out_t  res;
    logic       res_valid;
    logic       out_empty;
    logic       out_almost_full;

    assign datain_ready  = !in_full;
    assign dataout_valid = !out_empty;

    ////////////////////////////////////////////////////////////////////////////
    // Input FIFO, command controller, line buffer, max tree, output FIFO
    ////////////////////////////////////////////////////////////////////////////

    stream_fifo #(
        .payload_t (pixel_t),
        .DEPTH     (`POOL_FIFO_DEPTH),
        .AF_MARGIN (1)
    ) u_in_fifo (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (datain_valid),
        .wr_data     (datain),
        .rd_en       (in_pop),
        .rd_data     (in_head),
        .empty       (in_empty),
        .full        (in_full),
        .almost_full ()
    );

    pool_cmd_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .opcode          (opcode),
        .opcode_valid    (opcode_valid),
        .res_valid       (res_valid),
        .res_last        (res.last),
        .opcode_accept   (opcode_accept),
        .opcode_complete (opcode_complete),
        .cmd             (cmd),
        .map_start       (map_start)
    );

    line_buffer u_line_buffer (
        .clk             (clk),
        .rst             (rst),
        .cmd             (cmd),
        .map_start       (map_start),
        .in_pixel        (in_head),
        .in_empty        (in_empty),
        .out_almost_full (out_almost_full),
        .in_pop          (in_pop),
        .col             (col),
        .col_valid       (col_valid),
        .win_valid       (win_valid),
        .win_last        (win_last)
    );

    window_max u_window_max (
        .clk       (clk),
        .rst       (rst),
        .col       (col),
        .col_valid (col_valid),
        .win_valid (win_valid),
        .win_last  (win_last),
        .res       (res),
        .res_valid (res_valid)
    );

    // Margin covers every window still inside the max tree
    stream_fifo #(
        .payload_t (pool_out_t),
        .DEPTH     (`POOL_FIFO_DEPTH),
        .AF_MARGIN (`POOL_PIPE_DEPTH)
    ) u_out_fifo (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (res_valid),
        .wr_data     (res),
        .rd_en       (dataout_ready),
        .rd_data     (dataout),
        .empty       (out_empty),
        .full        (),
        .almost_full (out_almost_full)
    );

endmodule

`default_nettype wire

// ==== dv/pool_engine_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_config.svh"

module pool_engine_tb;

    import pool_cmd_pkg::*;
    import pixel_pkg::*;

    localparam int NUM_CMDS = 9;
    localparam int DIM_W    = `POOL_DIM_W;
    localparam int MAP_W    = `POOL_MAP_W;

    logic      clk;
    logic      rst;
    pool_cmd_t opcode;
    logic      opcode_valid;
    logic      opcode_accept;
    logic      opcode_complete;
    pixel_t    datain;
    logic      datain_valid;
    logic      datain_ready;
    pool_out_t dataout;
    logic      dataout_valid;
    logic      dataout_ready;

    // Command table for the whole run, built before reset is released
    string test_name [NUM_CMDS];
    int    cmd_rows  [NUM_CMDS];
    int    cmd_cols  [NUM_CMDS];
    int    cmd_maps  [NUM_CMDS];
    int    cmd_stall [NUM_CMDS];

    string              cur_test = "startup";
    int                 stall_pct = 0;
    int                 wd_cycles = 0;
    pixel_t             px_q [$];
    pool_out_t          exp_q [$];
    logic [MAP_W-1:0]   accept_cnt;
    logic [MAP_W-1:0]   complete_cnt;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    pool_engine_top dut (
        .clk             (clk),
        .rst             (rst),
        .opcode          (opcode),
        .opcode_valid    (opcode_valid),
        .opcode_accept   (opcode_accept),
        .opcode_complete (opcode_complete),
        .datain          (datain),
        .datain_valid    (datain_valid),
        .datain_ready    (datain_ready),
        .dataout         (dataout),
        .dataout_valid   (dataout_valid),
        .dataout_ready   (dataout_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_result(input pool_out_t exp, input pool_out_t act);
        if (exp !== act) begin
            $display("ERR %s: result expected value=%h last=%b, actual value=%h last=%b",
                     cur_test, exp.value, exp.last, act.value, act.last);
            abort_run();
        end
    endtask

    task automatic check_count(input string what, input logic [MAP_W-1:0] exp,
                               input logic [MAP_W-1:0] act);
        if (exp !== act) begin
            $display("ERR %s: %s expected %0d, actual %0d", cur_test, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s: %s expected %b, actual %b", cur_test, what, exp, act);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Window maxima of one map starting at px_q[base] in raster order
    task automatic model_map(input int base, input int rows, input int cols);
        pool_out_t r;
        pixel_t    p;
        for (int y = 2; y < rows; y++) begin
            for (int x = 2; x < cols; x++) begin
                r.value = '0;
                for (int dy = 0; dy < 3; dy++) begin
                    for (int dx = 0; dx < 3; dx++) begin
                        p = px_q[base + (y - dy) * cols + (x - dx)];
                        if (p > r.value) begin
                            r.value = p;
                        end
                    end
                end
                r.last = (y == rows - 1) && (x == cols - 1);
                exp_q.push_back(r);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic int rand_dim();
        return 3 + int'($urandom % 10);
    endfunction

    task automatic set_cmd(input int idx, input string name, input int rows,
                           input int cols, input int maps, input int stall);
        test_name[idx] = name;
        cmd_rows[idx]  = rows;
        cmd_cols[idx]  = cols;
        cmd_maps[idx]  = maps;
        cmd_stall[idx] = stall;
    endtask

    task automatic fill_table();
        set_cmd(0, "single_map", rand_dim(), rand_dim(), 1, 0);
        set_cmd(1, "multi_map", rand_dim(), rand_dim(), 3, 10);
        set_cmd(2, "back_pressure", rand_dim(), rand_dim(), 2, 60);
        set_cmd(3, "corner_3x3", 3, 3, 1, 20);
        set_cmd(4, "corner_3x_max_cols", 3, `POOL_MAX_COLS, 1, 20);
        for (int i = 5; i < NUM_CMDS; i++) begin
            set_cmd(i, $sformatf("back_to_back_%0d", i - 4), rand_dim(), rand_dim(),
                    1 + int'($urandom % 3), int'($urandom % 50));
        end
    endtask

    // Holds the command until the engine takes it
    task automatic send_opcode(input int idx);
        opcode.img_rows = DIM_W'(cmd_rows[idx]);
        opcode.img_cols = DIM_W'(cmd_cols[idx]);
        opcode.num_maps = MAP_W'(cmd_maps[idx]);
        opcode_valid    = 1'b1;
        @(negedge clk);
        while (!opcode_accept) begin
            @(negedge clk);
        end
        opcode_valid = 1'b0;
    endtask

    // Ready is stable from one falling edge to the next rising edge
    task automatic send_pixels();
        foreach (px_q[i]) begin
            while (($urandom % 100) < stall_pct / 2) begin
                datain_valid = 1'b0;
                @(negedge clk);
            end
            datain       = px_q[i];
            datain_valid = 1'b1;
            while (!datain_ready) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        datain_valid = 1'b0;
    endtask

    task automatic run_command(input int idx);
        int npix;
        npix      = cmd_rows[idx] * cmd_cols[idx];
        cur_test  = test_name[idx];
        stall_pct = cmd_stall[idx];
        px_q.delete();
        for (int m = 0; m < cmd_maps[idx]; m++) begin
            for (int p = 0; p < npix; p++) begin
                px_q.push_back(pixel_t'($urandom));
            end
            model_map(m * npix, cmd_rows[idx], cmd_cols[idx]);
        end
        fork
            send_opcode(idx);
            send_pixels();
        join
        // Counters and queue only change on falling edges
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0 || complete_cnt == MAP_W'(idx));
        check_count("accept pulses", MAP_W'(idx + 1), accept_cnt);
        check_count("complete pulses", MAP_W'(idx + 1), complete_cnt);
        @(negedge clk);
    endtask

    task automatic check_reset_state();
        cur_test = "reset_state";
        repeat (8) begin
            @(negedge clk);
            check_flag("dataout_valid", 1'b0, dataout_valid);
            check_flag("opcode_accept", 1'b0, opcode_accept);
            check_flag("opcode_complete", 1'b0, opcode_complete);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output side, pulse counters, watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        dataout_ready = 1'b0;
        accept_cnt    = '0;
        complete_cnt  = '0;
        forever begin
            @(negedge clk);
            if (opcode_accept) begin
                accept_cnt = accept_cnt + 1'b1;
            end
            if (opcode_complete) begin
                complete_cnt = complete_cnt + 1'b1;
                // Every result of the command is delivered or sits in the output FIFO
                if (exp_q.size() > `POOL_FIFO_DEPTH) begin
                    $display("Complete pulsed while %0d results were still missing",
                             exp_q.size());
                    abort_run();
                end
                check_flag("dataout_valid at complete", exp_q.size() != 0, dataout_valid);
            end
            dataout_ready = ($urandom % 100) >= stall_pct;
            if (dataout_ready && dataout_valid) begin
                if (exp_q.size() == 0) begin
                    $display("A result came out in %s that the model did not expect",
                             cur_test);
                    abort_run();
                end
                check_result(exp_q.pop_front(), dataout);
            end
        end
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the engine stopped making progress in %s",
                 wd_cycles, cur_test);
        abort_run();
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int total_pix;
        void'($urandom(32'h6fc5));
        rst          = 1'b1;
        opcode       = '0;
        opcode_valid = 1'b0;
        datain       = '0;
        datain_valid = 1'b0;

        fill_table();
        total_pix = 0;
        for (int i = 0; i < NUM_CMDS; i++) begin
            total_pix += cmd_rows[i] * cmd_cols[i] * cmd_maps[i];
        end
        wd_cycles = 20 * total_pix + 1000;

        repeat (2) @(negedge clk);
        rst = 1'b0;

        check_reset_state();
        for (int i = 0; i < NUM_CMDS; i++) begin
            run_command(i);
        end

        // No stray pulses or results once the engine is idle
        repeat (20) @(negedge clk);
        cur_test = "final_counts";
        check_flag("dataout_valid", 1'b0, dataout_valid);
        @(posedge clk);
        check_count("accept pulses", MAP_W'(NUM_CMDS), accept_cnt);
        check_count("complete pulses", MAP_W'(NUM_CMDS), complete_cnt);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+src
src/pool_cmd_pkg.sv
src/pixel_pkg.sv
src/stream_fifo.sv
src/pool_cmd_ctrl.sv
src/line_buffer.sv
src/window_max.sv
src/pool_engine_top.sv
dv/pool_engine_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the pooling engine testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module pool_engine_tb \
    -f all.f -o pool_engine_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/pool_engine_sim > sim.log 2>&1
cat sim.log

grep -q "TESTS PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
